/* hw/lsu_isa_pkg.sv */
package lsu_isa_pkg;

    //**********************************************************
    // access kinds and sizes
    //**********************************************************

    // load or store, one bit as in the decode stage
    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_t;

    // access size, log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } lsu_size_t;

    //**********************************************************
    // command from the execute side
    //**********************************************************

    // store data sits in the low bits, not yet lane aligned
    typedef struct packed {
        lsu_op_t     op;
        lsu_size_t   size;
        // set for lbu, lhu, lwu
        logic        is_unsigned;
        logic [31:0] addr;
        logic [63:0] wdata;
    } lsu_cmd_t;

    //**********************************************************
    // one memory doubleword, seen by lane
    //**********************************************************

    // store side places lanes, load side picks them back out
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } lsu_dword_u;

endpackage

/* hw/lsu_mem_pkg.sv */
package lsu_mem_pkg;

    import lsu_isa_pkg::*;

    //**********************************************************
    // bus widths
    //**********************************************************
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int STRB_W     = DATA_W / 8;
    localparam int BYTE_OFF_W = $clog2(STRB_W);

    //**********************************************************
    // address map
    //**********************************************************

    // anything outside [base, limit] goes out on the mmio port
    localparam logic [ADDR_W-1:0] CACHED_BASE  = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] CACHED_LIMIT = 32'h8800_0000;

    // local data memory, the window aliases onto it
    localparam int LOCAL_WORDS = 512;
    localparam int LOCAL_IDX_W = $clog2(LOCAL_WORDS);

    // request queue between former and router
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // request after forming, strobe and data already in their lanes
    typedef struct packed {
        lsu_op_t             op;
        lsu_size_t           size;
        logic                is_unsigned;
        logic                uncached;
        logic [ADDR_W-1:0]   addr;
        logic [STRB_W-1:0]   strb;
        logic [DATA_W-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                write;
        logic [ADDR_W-1:0]   addr;
        logic [STRB_W-1:0]   strb;
        logic [DATA_W-1:0]   wdata;
    } mmio_req_t;

endpackage

/* hw/lsu_req_former.sv */
`timescale 1ns/1ps

module lsu_req_former
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,

    input  lsu_cmd_t cmd_i,
    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,

    output mem_req_t req_o,
    output logic     req_valid_o,
    input  logic     req_ready_i
);

    logic [STRB_W-1:0]     base_strb;
    logic [STRB_W-1:0]     shifted_strb;
    logic [BYTE_OFF_W-1:0] byte_off;
    lsu_dword_u            store_lane;
    logic                  uncached;
    mem_req_t              req_next;

    assign byte_off = cmd_i.addr[BYTE_OFF_W-1:0];

    //**********************************************************
    // strobe and lane placement
    //**********************************************************
    always_comb begin
        store_lane = '0;
        case (cmd_i.size)
            SIZE_B: begin
                base_strb                    = 8'h01;
                store_lane.b[byte_off]       = cmd_i.wdata[7:0];
            end
            SIZE_H: begin
                base_strb                    = 8'h03;
                store_lane.h[byte_off[2:1]]  = cmd_i.wdata[15:0];
            end
            SIZE_W: begin
                base_strb                    = 8'h0f;
                store_lane.w[byte_off[2]]    = cmd_i.wdata[31:0];
            end
            default: begin
                base_strb                    = 8'hff;
                store_lane.d                 = cmd_i.wdata;
            end
        endcase
    end

    // aligned accesses only, so the shift never runs off the top
    assign shifted_strb = base_strb << byte_off;

    // same window test as the core top
    assign uncached = (cmd_i.addr < CACHED_BASE) || (cmd_i.addr > CACHED_LIMIT);

    always_comb begin
        req_next.op          = cmd_i.op;
        req_next.size        = cmd_i.size;
        req_next.is_unsigned = cmd_i.is_unsigned;
        req_next.uncached    = uncached;
        req_next.addr        = cmd_i.addr;
        req_next.strb        = shifted_strb;
        // loads carry no write data
        req_next.wdata       = (cmd_i.op == LSU_STORE) ? store_lane.d : '0;
    end

    //**********************************************************
    // output register
    //**********************************************************
    assign cmd_ready_o = !req_valid_o || req_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_valid_o <= 1'b0;
        end else if (cmd_ready_o) begin
            req_valid_o <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            req_o <= req_next;
        end
    end

endmodule

/* hw/lsu_req_queue.sv */
`timescale 1ns/1ps

module lsu_req_queue
    import lsu_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,

    input  mem_req_t in_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,

    output mem_req_t out_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    mem_req_t               entry_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   push;
    logic                   pop;

    // full blocks a push even when a pop happens in the same cycle
    assign in_ready_o  = (count != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
    assign out_valid_o = (count != '0);
    assign out_o       = entry_q[rd_ptr];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage, depth is a power of two so the pointers wrap by themselves
    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[wr_ptr] <= in_i;
        end
    end

endmodule

/* hw/lsu_mem_router.sv */
`timescale 1ns/1ps

module lsu_mem_router
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  mem_req_t          req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,

    output mmio_req_t         mmio_req_o,
    output logic              mmio_req_valid_o,
    input  logic              mmio_req_ready_i,
    input  logic              mmio_rsp_valid_i,
    input  logic [DATA_W-1:0] mmio_rdata_i,

    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output logic              rsp_is_load_o,
    output logic [DATA_W-1:0] rsp_data_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOCAL,
        ST_MMIO_ISSUE,
        ST_MMIO_WAIT,
        ST_RSP
    } state_t;

    state_t                 state;
    state_t                 state_next;
    mem_req_t               cur_q;
    lsu_dword_u             rd_word_q;
    logic [DATA_W-1:0]      local_mem [LOCAL_WORDS];
    logic [LOCAL_IDX_W-1:0] local_idx;
    logic [BYTE_OFF_W-1:0]  byte_off;
    logic [DATA_W-1:0]      load_ext;
    logic                   pop;
    logic                   local_pop;

    assign req_ready_o = (state == ST_IDLE);
    assign pop         = req_ready_o && req_valid_i;
    assign local_pop   = pop && !req_i.uncached;

    // index wraps inside the window
    assign local_idx = req_i.addr[BYTE_OFF_W +: LOCAL_IDX_W];

    //**********************************************************
    // routing fsm
    //**********************************************************
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_next = req_i.uncached ? ST_MMIO_ISSUE : ST_LOCAL;
                end
            end
            // first cycle with the local read word on the output
            ST_LOCAL: begin
                state_next = rsp_ready_i ? ST_IDLE : ST_RSP;
            end
            ST_MMIO_ISSUE: begin
                if (mmio_req_ready_i) begin
                    state_next = ST_MMIO_WAIT;
                end
            end
            // stores wait here too, like the write response channel
            ST_MMIO_WAIT: begin
                if (mmio_rsp_valid_i) begin
                    state_next = ST_RSP;
                end
            end
            ST_RSP: begin
                if (rsp_ready_i) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // current request, held until its response is taken
    always_ff @(posedge clk) begin
        if (pop) begin
            cur_q <= req_i;
        end
    end

    //**********************************************************
    // local memory and read word
    //**********************************************************
    always_ff @(posedge clk) begin
        if (local_pop) begin
            rd_word_q <= local_mem[local_idx];
            if (req_i.op == LSU_STORE) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (req_i.strb[i]) begin
                        local_mem[local_idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                    end
                end
            end
        end else if ((state == ST_MMIO_WAIT) && mmio_rsp_valid_i) begin
            rd_word_q <= mmio_rdata_i;
        end
    end

    // mmio request straight from the held request
    assign mmio_req_valid_o = (state == ST_MMIO_ISSUE);
    assign mmio_req_o.write = (cur_q.op == LSU_STORE);
    assign mmio_req_o.addr  = cur_q.addr;
    assign mmio_req_o.strb  = cur_q.strb;
    assign mmio_req_o.wdata = cur_q.wdata;

    //**********************************************************
    // load lane select and extension
    //**********************************************************
    assign byte_off = cur_q.addr[BYTE_OFF_W-1:0];

    always_comb begin
        case (cur_q.size)
            SIZE_B: load_ext = cur_q.is_unsigned ?
                {56'b0, rd_word_q.b[byte_off]} :
                {{56{rd_word_q.b[byte_off][7]}}, rd_word_q.b[byte_off]};
            SIZE_H: load_ext = cur_q.is_unsigned ?
                {48'b0, rd_word_q.h[byte_off[2:1]]} :
                {{48{rd_word_q.h[byte_off[2:1]][15]}}, rd_word_q.h[byte_off[2:1]]};
            SIZE_W: load_ext = cur_q.is_unsigned ?
                {32'b0, rd_word_q.w[byte_off[2]]} :
                {{32{rd_word_q.w[byte_off[2]][31]}}, rd_word_q.w[byte_off[2]]};
            default: load_ext = rd_word_q.d;
        endcase
    end

    assign rsp_valid_o   = (state == ST_LOCAL) || (state == ST_RSP);
    assign rsp_is_load_o = (cur_q.op == LSU_LOAD);
    // stores answer with zero
    assign rsp_data_o    = rsp_is_load_o ? load_ext : '0;

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    // command in
    input  lsu_cmd_t          cmd_i,
    input  logic              cmd_valid_i,
    output logic              cmd_ready_o,

    // in-order response
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output logic              rsp_is_load_o,
    output logic [DATA_W-1:0] rsp_data_o,

    // uncached port
    output mmio_req_t         mmio_req_o,
    output logic              mmio_req_valid_o,
    input  logic              mmio_req_ready_i,
    input  logic              mmio_rsp_valid_i,
    input  logic [DATA_W-1:0] mmio_rdata_i
);

    mem_req_t formed_req;
    logic     formed_valid;
    logic     formed_ready;
    mem_req_t head_req;
    logic     head_valid;
    logic     head_ready;

    lsu_req_former lsu_req_former_inst (
        .clk         (clk         ),
        .rst_n_i     (rst_n_i     ),
        .cmd_i       (cmd_i       ),
        .cmd_valid_i (cmd_valid_i ),
        .cmd_ready_o (cmd_ready_o ),
        .req_o       (formed_req  ),
        .req_valid_o (formed_valid),
        .req_ready_i (formed_ready)
    );

    lsu_req_queue lsu_req_queue_inst (
        .clk         (clk         ),
        .rst_n_i     (rst_n_i     ),
        .in_i        (formed_req  ),
        .in_valid_i  (formed_valid),
        .in_ready_o  (formed_ready),
        .out_o       (head_req    ),
        .out_valid_o (head_valid  ),
        .out_ready_i (head_ready  )
    );

    lsu_mem_router lsu_mem_router_inst (
        .clk              (clk             ),
        .rst_n_i          (rst_n_i         ),
        .req_i            (head_req        ),
        .req_valid_i      (head_valid      ),
        .req_ready_o      (head_ready      ),
        .mmio_req_o       (mmio_req_o      ),
        .mmio_req_valid_o (mmio_req_valid_o),
        .mmio_req_ready_i (mmio_req_ready_i),
        .mmio_rsp_valid_i (mmio_rsp_valid_i),
        .mmio_rdata_i     (mmio_rdata_i    ),
        .rsp_valid_o      (rsp_valid_o     ),
        .rsp_ready_i      (rsp_ready_i     ),
        .rsp_is_load_o    (rsp_is_load_o   ),
        .rsp_data_o       (rsp_data_o      )
    );

endmodule

/* tb/tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
;

    typedef struct packed {
        logic        is_load;
        logic [63:0] data;
    } exp_rsp_t;

    logic              clk;
    logic              rst_n_i;
    lsu_cmd_t          cmd_i;
    logic              cmd_valid_i;
    logic              cmd_ready_o;
    logic              rsp_valid_o;
    logic              rsp_ready_i;
    logic              rsp_is_load_o;
    logic [DATA_W-1:0] rsp_data_o;
    mmio_req_t         mmio_req_o;
    logic              mmio_req_valid_o;
    logic              mmio_req_ready_i;
    logic              mmio_rsp_valid_i;
    logic [DATA_W-1:0] mmio_rdata_i;

    exp_rsp_t    rsp_exp [$];
    mmio_req_t   mmio_exp [$];
    logic [63:0] ref_local [LOCAL_WORDS];
    logic [63:0] ref_mmio [logic [31:0]];
    logic [63:0] dev_mem [logic [31:0]];
    logic [31:0] lcg_state = 32'h5ea0;
    string       test_name = "reset";
    int          errors;
    int          err_at_start;
    int          tests_run;
    int          tests_failed;
    int          rsp_count;
    int          cmd_count;
    bit          rand_ready;
    exp_rsp_t    exp_r;

    lsu_top lsu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog on the whole run
    initial begin
        repeat (200000) @(posedge clk);
        $display("timeout: simulation did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    //************************************************************
    // reference rules
    //************************************************************
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    function automatic logic [63:0] fill_word(logic [31:0] addr);
        return {addr ^ 32'h5a5a_0f0f, ~addr};
    endfunction

    function automatic logic [63:0] size_mask(lsu_size_t size);
        int nb;
        nb = 1 << int'(size);
        return (nb == 8) ? '1 : ((64'd1 << (nb * 8)) - 64'd1);
    endfunction

    function automatic logic [7:0] strb_of(lsu_size_t size, logic [31:0] addr);
        int nb;
        nb = 1 << int'(size);
        return 8'(((1 << nb) - 1) << addr[2:0]);
    endfunction

    function automatic logic [63:0] lane_data(lsu_size_t size, logic [31:0] addr,
                                              logic [63:0] wdata);
        return (wdata & size_mask(size)) << (addr[2:0] * 8);
    endfunction

    function automatic logic [63:0] merge(logic [63:0] old, logic [7:0] strb,
                                          logic [63:0] data);
        logic [63:0] res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // pick the lane then sign or zero fill
    function automatic logic [63:0] extend(logic [63:0] word, lsu_size_t size,
                                           logic [31:0] addr, logic uns);
        logic [63:0] v;
        logic [63:0] m;
        int          nb;
        nb = 1 << int'(size);
        m  = size_mask(size);
        v  = (word >> (addr[2:0] * 8)) & m;
        if (!uns && nb < 8 && v[nb*8-1]) begin
            v = v | ~m;
        end
        return v;
    endfunction

    function automatic lsu_cmd_t mk(bit st, int sz, bit uns, logic [31:0] a,
                                    logic [63:0] d);
        lsu_cmd_t c;
        c.op          = st ? LSU_STORE : LSU_LOAD;
        c.size        = lsu_size_t'(sz);
        c.is_unsigned = uns;
        c.addr        = a;
        c.wdata       = d;
        return c;
    endfunction

    // expected response and mmio request in command order
    task automatic record_cmd(lsu_cmd_t c);
        logic        unc;
        logic [31:0] key;
        logic [63:0] old;
        logic [7:0]  strb;
        logic [63:0] lane;
        logic [8:0]  idx;
        unc  = (c.addr < CACHED_BASE) || (c.addr > CACHED_LIMIT);
        key  = {c.addr[31:3], 3'b000};
        idx  = c.addr[11:3];
        strb = strb_of(c.size, c.addr);
        lane = lane_data(c.size, c.addr, c.wdata);
        if (unc) begin
            old = ref_mmio.exists(key) ? ref_mmio[key] : fill_word(key);
            mmio_exp.push_back(mmio_req_t'{c.op == LSU_STORE, c.addr, strb, lane});
        end else begin
            old = ref_local[idx];
        end
        if (c.op == LSU_STORE) begin
            if (unc) begin
                ref_mmio[key] = merge(old, strb, lane);
            end else begin
                ref_local[idx] = merge(old, strb, lane);
            end
            rsp_exp.push_back(exp_rsp_t'{1'b0, 64'd0});
        end else begin
            rsp_exp.push_back(exp_rsp_t'{1'b1, extend(old, c.size, c.addr, c.is_unsigned)});
        end
        cmd_count++;
    endtask

    //************************************************************
    // drivers
    //************************************************************
    task automatic try_cmd(lsu_cmd_t c, int limit, output bit ok);
        int t;
        t           = 0;
        ok          = 1'b0;
        cmd_i       = c;
        cmd_valid_i = 1'b1;
        while (!ok && t < limit) begin
            @(negedge clk);
            ok = cmd_ready_o;
            @(posedge clk);
            #1;
            t++;
        end
        cmd_valid_i = 1'b0;
        if (ok) record_cmd(c);
    endtask

    task automatic send_cmd(lsu_cmd_t c);
        bit ok;
        try_cmd(c, 500, ok);
        if (!ok) begin
            errors++;
            $display("%s: command not accepted before the timeout", test_name);
        end
    endtask

    task automatic make_rand_cmd(bit allow_mmio, output lsu_cmd_t c);
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  off;
        int          nb;
        r   = lcg_next();
        nb  = 1 << int'(r[1:0]);
        off = r[12:10] & 3'(8 - nb);
        case (allow_mmio ? r[5:4] : 2'b00)
            2'd2:    a = 32'h1000_0000;
            2'd3:    a = 32'h9000_0000;
            // alias offset on top of the cached base
            default: a = CACHED_BASE + {6'd0, r[26:13], 12'h000};
        endcase
        a = a + {25'd0, r[9:6], off};
        c = mk(r[2], int'(r[1:0]), r[3], a, {lcg_next(), lcg_next()});
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (rsp_exp.size() != 0 && t < 5000) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (rsp_exp.size() != 0) begin
            errors++;
            $display("%s: %0d responses still missing after the timeout",
                     test_name, rsp_exp.size());
        end
    endtask

    task automatic begin_test(string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        wait_drain();
        // every uncached access has been answered, so its request was seen
        if (mmio_exp.size() != 0) begin
            errors++;
            $display("%s: %0d uncached accesses never appeared on the MMIO port",
                     test_name, mmio_exp.size());
            mmio_exp.delete();
        end
        tests_run++;
        if (errors != err_at_start) tests_failed++;
        $display("test %-14s %s", test_name, (errors == err_at_start) ? "ok" : "failed");
    endtask

    //************************************************************
    // mmio device model
    //************************************************************
    initial begin
        mmio_req_t   got;
        mmio_req_t   e;
        logic [31:0] key;
        logic [63:0] word;
        mmio_req_ready_i = 1'b0;
        mmio_rsp_valid_i = 1'b0;
        mmio_rdata_i     = '0;
        forever begin
            @(negedge clk);
            if (rst_n_i && mmio_req_valid_o) begin
                got = mmio_req_o;
                if (mmio_exp.size() == 0) begin
                    errors++;
                    $display("%s: MMIO request at %h without an uncached command",
                             test_name, got.addr);
                end else begin
                    e = mmio_exp.pop_front();
                    assert (got.write == e.write && got.addr == e.addr &&
                            got.strb == e.strb && (!e.write || got.wdata == e.wdata))
                    else begin
                        errors++;
                        $display("[ERROR] %s: expected mmio %h, actual %h", test_name, e, got);
                    end
                end
                @(posedge clk);
                #1;
                repeat (int'(lcg_next() % 32'd4)) begin
                    @(posedge clk);
                    #1;
                end
                mmio_req_ready_i = 1'b1;
                @(posedge clk);
                #1;
                mmio_req_ready_i = 1'b0;
                key  = {got.addr[31:3], 3'b000};
                word = dev_mem.exists(key) ? dev_mem[key] : fill_word(key);
                if (got.write) dev_mem[key] = merge(word, got.strb, got.wdata);
                repeat (int'(lcg_next() % 32'd5)) begin
                    @(posedge clk);
                    #1;
                end
                mmio_rdata_i     = word;
                mmio_rsp_valid_i = 1'b1;
                @(posedge clk);
                #1;
                mmio_rsp_valid_i = 1'b0;
            end
        end
    end

    // random response back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (rand_ready) rsp_ready_i = (lcg_next() % 32'd3) != 0;
        end
    end

    //************************************************************
    // checks
    //************************************************************
    always @(negedge clk) begin
        if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
            rsp_count++;
            if (rsp_exp.size() == 0) begin
                errors++;
                $display("%s: response arrived with no command outstanding", test_name);
            end else begin
                exp_r = rsp_exp.pop_front();
                assert (rsp_data_o === exp_r.data && rsp_is_load_o === exp_r.is_load)
                else begin
                    errors++;
                    $display("[ERROR] %s: expected %b/%h, actual %b/%h", test_name,
                             exp_r.is_load, exp_r.data, rsp_is_load_o, rsp_data_o);
                end
            end
        end
    end

    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
    else begin
        errors++;
        $display("%s: response changed while rsp_ready_i was low", test_name);
    end

    mmio_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        mmio_req_valid_o && !mmio_req_ready_i |=> mmio_req_valid_o && $stable(mmio_req_o))
    else begin
        errors++;
        $display("%s: MMIO request changed before it was taken", test_name);
    end

    //************************************************************
    // test sequence
    //************************************************************
    initial begin
        lsu_cmd_t c;
        bit       ok;
        bit       full;
        rst_n_i     = 1'b0;
        cmd_i       = '0;
        cmd_valid_i = 1'b0;
        rsp_ready_i = 1'b1;
        rand_ready  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        begin_test("reset");
        @(negedge clk);
        assert (!rsp_valid_o && !mmio_req_valid_o && cmd_ready_o)
        else begin
            errors++;
            $display("[ERROR] %s: expected 001, actual %b%b%b", test_name,
                     rsp_valid_o, mmio_req_valid_o, cmd_ready_o);
        end
        repeat (5) @(posedge clk);
        #1;
        end_test();

        begin_test("store_merge");
        // every local word that later tests load from
        for (int i = 0; i < 16; i++) begin
            send_cmd(mk(1, 3, 0, CACHED_BASE + 32'(i * 8), {lcg_next(), lcg_next()}));
        end
        send_cmd(mk(1, 3, 0, 32'h8000_0040, 64'h0011_2233_4455_6677));
        send_cmd(mk(1, 0, 0, 32'h8000_0043, 64'h0000_0000_0000_00a5));
        send_cmd(mk(1, 1, 0, 32'h8000_0046, 64'h0000_0000_0000_beef));
        send_cmd(mk(0, 3, 0, 32'h8000_0040, 64'd0));
        end_test();

        begin_test("load_extend");
        send_cmd(mk(1, 3, 0, 32'h8000_0018, 64'hf1e2_d3c4_b5a6_9788));
        for (int uns = 0; uns < 2; uns++) begin
            for (int sz = 0; sz < 4; sz++) begin
                for (int off = 0; off < 8; off += (1 << sz)) begin
                    send_cmd(mk(0, sz, uns[0], 32'h8000_0018 + 32'(off), 64'd0));
                end
            end
        end
        end_test();

        begin_test("uncached");
        send_cmd(mk(1, 2, 0, 32'h1000_0010, 64'h0000_0000_cafe_f00d));
        send_cmd(mk(0, 2, 0, 32'h1000_0010, 64'd0));
        send_cmd(mk(0, 0, 1, 32'h1000_0013, 64'd0));
        send_cmd(mk(1, 1, 0, 32'h9000_0006, 64'h0000_0000_0000_8421));
        send_cmd(mk(0, 3, 0, 32'h9000_0000, 64'd0));
        send_cmd(mk(0, 1, 0, 32'h9000_0006, 64'd0));
        send_cmd(mk(0, 3, 0, 32'h1000_0100, 64'd0));
        send_cmd(mk(1, 0, 0, 32'h8000_0008, 64'h0000_0000_0000_0081));
        // the limit itself is still cached
        send_cmd(mk(0, 1, 0, CACHED_LIMIT, 64'd0));
        end_test();

        begin_test("backpressure");
        rsp_ready_i = 1'b0;
        full        = 1'b0;
        for (int i = 0; i < 12 && !full; i++) begin
            make_rand_cmd(0, c);
            try_cmd(c, 4, ok);
            full = !ok;
        end
        if (!full) begin
            errors++;
            $display("%s: cmd_ready_o never fell with responses stalled", test_name);
        end
        repeat (6) @(posedge clk);
        #1;
        rsp_ready_i = 1'b1;
        end_test();

        begin_test("random_mix");
        rsp_count  = 0;
        cmd_count  = 0;
        rand_ready = 1'b1;
        for (int i = 0; i < 200; i++) begin
            make_rand_cmd(1, c);
            send_cmd(c);
        end
        wait_drain();
        rand_ready  = 1'b0;
        rsp_ready_i = 1'b1;
        if (rsp_count != cmd_count) begin
            errors++;
            $display("[ERROR] %s: expected %0d responses, actual %0d", test_name,
                     cmd_count, rsp_count);
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* lsu_top.f */
hw/lsu_isa_pkg.sv
hw/lsu_mem_pkg.sv
hw/lsu_req_former.sv
hw/lsu_req_queue.sv
hw/lsu_mem_router.sv
hw/lsu_top.sv
tb/tb_lsu_top.sv

/* Makefile */
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
